// ==== rtl/spu_pkg.sv ====
`default_nettype none

// architectural types shared by both execution pipes
package spu_pkg;

    localparam int reg_addr_width = 7;
    localparam int quad_width     = 128;
    localparam int unit_id_width  = 3;
    localparam int unit_lat_width = 4;

    // index into the 128-entry register file
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // one full quadword register value
    typedef logic [quad_width-1:0] quad_t;

    // execution unit that produced a result, zero marks a bubble
    typedef logic [unit_id_width-1:0] unit_id_t;

    // cycles from issue until the unit's result is available
    typedef logic [unit_lat_width-1:0] unit_lat_t;

endpackage

`default_nettype wire

// ==== rtl/fwd_pkg.sv ====
`default_nettype none

// layout of the in-flight result stages seen by the bypass network
package fwd_pkg;

    // stages 1 to 7 plus the output stage
    localparam int num_stages = 8;

    // operand count of the even and odd pipes
    localparam int ep_operands = 3;
    localparam int op_operands = 2;

    // stage index runs 1 to 8 so it needs four bits
    typedef logic [3:0] stage_idx_t;

    // field positions, packed from the most significant bit as
    // unit id, result value, write enable, target address, unit latency
    localparam int unit_lat_lsb   = 0;
    localparam int rt_address_lsb = unit_lat_lsb + spu_pkg::unit_lat_width;
    localparam int wrt_en_bit     = rt_address_lsb + spu_pkg::reg_addr_width;
    localparam int rt_value_lsb   = wrt_en_bit + 1;
    localparam int unit_id_lsb    = rt_value_lsb + spu_pkg::quad_width;

    localparam int stage_word_width = unit_id_lsb + spu_pkg::unit_id_width;

    typedef logic [stage_word_width-1:0] stage_word_t;

endpackage

`default_nettype wire

// ==== rtl/result_tap.sv ====
`default_nettype none

module result_tap (
    input  fwd_pkg::stage_word_t stage       [fwd_pkg::num_stages],
    output logic                 stage_ready [fwd_pkg::num_stages],
    output spu_pkg::reg_addr_t   stage_addr  [fwd_pkg::num_stages],
    output spu_pkg::quad_t       stage_value [fwd_pkg::num_stages]
);

    for (genvar i = 0; i < fwd_pkg::num_stages; i++) begin : g_stage
        spu_pkg::unit_id_t   unit_id;
        spu_pkg::unit_lat_t  unit_lat;
        logic                wrt_en;
        fwd_pkg::stage_idx_t stage_idx;

        assign unit_id  = stage[i][fwd_pkg::unit_id_lsb +: spu_pkg::unit_id_width];
        assign unit_lat = stage[i][fwd_pkg::unit_lat_lsb +: spu_pkg::unit_lat_width];
        assign wrt_en   = stage[i][fwd_pkg::wrt_en_bit];

        assign stage_addr[i]  = stage[i][fwd_pkg::rt_address_lsb +: spu_pkg::reg_addr_width];
        assign stage_value[i] = stage[i][fwd_pkg::rt_value_lsb +: spu_pkg::quad_width];

        // array slot 0 is stage 1, the last slot is the output stage (8)
        assign stage_idx = fwd_pkg::stage_idx_t'(i + 1);

        // the result exists once the instruction has travelled at least
        // as many stages as its unit needs to compute it
        assign stage_ready[i] = (unit_id != '0) && wrt_en && (unit_lat <= stage_idx);
    end

endmodule

`default_nettype wire

// ==== rtl/operand_select.sv ====
`default_nettype none

module operand_select (
    input  logic               stage_ready [fwd_pkg::num_stages],
    input  spu_pkg::reg_addr_t stage_addr  [fwd_pkg::num_stages],
    input  spu_pkg::quad_t     stage_value [fwd_pkg::num_stages],
    input  spu_pkg::reg_addr_t src_addr,
    input  spu_pkg::quad_t     reg_value,
    output spu_pkg::quad_t     operand
);

    logic [fwd_pkg::num_stages-1:0] hit;

    for (genvar i = 0; i < fwd_pkg::num_stages; i++) begin : g_hit
        assign hit[i] = stage_ready[i] && (stage_addr[i] == src_addr);
    end

    // walk from the output stage towards stage 1 so that the youngest
    // matching result is the one left on the operand
    always_comb begin
        operand = reg_value;
        for (int i = fwd_pkg::num_stages - 1; i >= 0; i--) begin
            if (hit[i]) begin
                operand = stage_value[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pipe_bypass.sv ====
`default_nettype none

module pipe_bypass #(
    parameter int num_operands = 1
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 issue_valid,
    input  fwd_pkg::stage_word_t stage     [fwd_pkg::num_stages],
    input  spu_pkg::reg_addr_t   src_addr  [num_operands],
    input  spu_pkg::quad_t       reg_value [num_operands],
    output logic                 operand_valid,
    output spu_pkg::quad_t       operand   [num_operands]
);

    logic               stage_ready [fwd_pkg::num_stages];
    spu_pkg::reg_addr_t stage_addr  [fwd_pkg::num_stages];
    spu_pkg::quad_t     stage_value [fwd_pkg::num_stages];
    spu_pkg::quad_t     resolved    [num_operands];

    // one decode of the stage words is shared by every operand of the pipe
    result_tap i_result_tap (
        .stage       (stage),
        .stage_ready (stage_ready),
        .stage_addr  (stage_addr),
        .stage_value (stage_value)
    );

    for (genvar k = 0; k < num_operands; k++) begin : g_operand
        operand_select i_operand_select (
            .stage_ready (stage_ready),
            .stage_addr  (stage_addr),
            .stage_value (stage_value),
            .src_addr    (src_addr[k]),
            .reg_value   (reg_value[k]),
            .operand     (resolved[k])
        );
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            operand_valid <= 1'b0;
        end else begin
            operand_valid <= issue_valid;
        end
    end

    // operands hold their last issued values between issues
    always_ff @(posedge clock) begin
        if (issue_valid) begin
            for (int k = 0; k < num_operands; k++) begin
                operand[k] <= resolved[k];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/forward_unit.sv ====
`default_nettype none

module forward_unit (
    input  logic                 clock,
    input  logic                 reset,

    input  logic                 ep_issue_valid,
    input  fwd_pkg::stage_word_t ep_stage [fwd_pkg::num_stages],
    input  spu_pkg::reg_addr_t   ra_address_ep,
    input  spu_pkg::reg_addr_t   rb_address_ep,
    input  spu_pkg::reg_addr_t   rc_address_ep,
    input  spu_pkg::quad_t       ra_value_ep,
    input  spu_pkg::quad_t       rb_value_ep,
    input  spu_pkg::quad_t       rc_value_ep,

    input  logic                 op_issue_valid,
    input  fwd_pkg::stage_word_t op_stage [fwd_pkg::num_stages],
    input  spu_pkg::reg_addr_t   ra_address_op,
    input  spu_pkg::reg_addr_t   rb_address_op,
    input  spu_pkg::quad_t       ra_value_op,
    input  spu_pkg::quad_t       rb_value_op,

    output logic                 ep_operand_valid,
    output spu_pkg::quad_t       ra_value_fw_ep,
    output spu_pkg::quad_t       rb_value_fw_ep,
    output spu_pkg::quad_t       rc_value_fw_ep,

    output logic                 op_operand_valid,
    output spu_pkg::quad_t       ra_value_fw_op,
    output spu_pkg::quad_t       rb_value_fw_op
);

    // operand slots are ordered ra, rb, rc in both pipes
    spu_pkg::reg_addr_t ep_src_addr  [fwd_pkg::ep_operands];
    spu_pkg::quad_t     ep_reg_value [fwd_pkg::ep_operands];
    spu_pkg::quad_t     ep_operand   [fwd_pkg::ep_operands];

    spu_pkg::reg_addr_t op_src_addr  [fwd_pkg::op_operands];
    spu_pkg::quad_t     op_reg_value [fwd_pkg::op_operands];
    spu_pkg::quad_t     op_operand   [fwd_pkg::op_operands];

    assign ep_src_addr[0] = ra_address_ep;
    assign ep_src_addr[1] = rb_address_ep;
    assign ep_src_addr[2] = rc_address_ep;

    assign ep_reg_value[0] = ra_value_ep;
    assign ep_reg_value[1] = rb_value_ep;
    assign ep_reg_value[2] = rc_value_ep;

    assign op_src_addr[0] = ra_address_op;
    assign op_src_addr[1] = rb_address_op;

    assign op_reg_value[0] = ra_value_op;
    assign op_reg_value[1] = rb_value_op;

    // even pipe only sees its own in-flight results
    pipe_bypass #(
        .num_operands (fwd_pkg::ep_operands)
    ) i_ep_bypass (
        .clock         (clock),
        .reset         (reset),
        .issue_valid   (ep_issue_valid),
        .stage         (ep_stage),
        .src_addr      (ep_src_addr),
        .reg_value     (ep_reg_value),
        .operand_valid (ep_operand_valid),
        .operand       (ep_operand)
    );

    // odd pipe has its own chain, no results cross between the pipes
    pipe_bypass #(
        .num_operands (fwd_pkg::op_operands)
    ) i_op_bypass (
        .clock         (clock),
        .reset         (reset),
        .issue_valid   (op_issue_valid),
        .stage         (op_stage),
        .src_addr      (op_src_addr),
        .reg_value     (op_reg_value),
        .operand_valid (op_operand_valid),
        .operand       (op_operand)
    );

    assign ra_value_fw_ep = ep_operand[0];
    assign rb_value_fw_ep = ep_operand[1];
    assign rc_value_fw_ep = ep_operand[2];

    assign ra_value_fw_op = op_operand[0];
    assign rb_value_fw_op = op_operand[1];

endmodule

`default_nettype wire

// ==== dv/forward_unit_chk.sv ====
`default_nettype none

module forward_unit_chk (
    input logic clock,
    input logic reset,
    input logic ep_issue_valid,
    input logic op_issue_valid,
    input logic ep_operand_valid,
    input logic op_operand_valid
);

    // the operand register comes out of reset empty on both pipes
    ep_low_after_reset: assert property (@(posedge clock) reset |=> !ep_operand_valid)
        else $error("even pipe operand valid high in the cycle after reset");

    op_low_after_reset: assert property (@(posedge clock) reset |=> !op_operand_valid)
        else $error("odd pipe operand valid high in the cycle after reset");

    // each issue shows up exactly one cycle later
    ep_follows_issue: assert property (@(posedge clock)
            !reset |=> (ep_operand_valid == $past(ep_issue_valid)))
        else $error("even pipe operand valid does not follow issue valid");

    op_follows_issue: assert property (@(posedge clock)
            !reset |=> (op_operand_valid == $past(op_issue_valid)))
        else $error("odd pipe operand valid does not follow issue valid");

endmodule

bind forward_unit forward_unit_chk i_forward_unit_chk (
    .clock            (clock),
    .reset            (reset),
    .ep_issue_valid   (ep_issue_valid),
    .op_issue_valid   (op_issue_valid),
    .ep_operand_valid (ep_operand_valid),
    .op_operand_valid (op_operand_valid)
);

`default_nettype wire

// ==== dv/forward_unit_tb.sv ====
`default_nettype none

module forward_unit_tb;

    localparam int clock_period = 8;
    localparam int reset_cycles = 4;
    localparam int test_cycles  = 200;
    localparam int num_tests    = 6;
    localparam int watchdog_cycles = reset_cycles + num_tests * (test_cycles + 2) + 100;

    // stimulus shapes for the stage entries
    localparam int mode_random   = 0;
    localparam int mode_none     = 1;
    localparam int mode_ready    = 2;
    localparam int mode_blocked  = 3;
    localparam int mode_priority = 4;
    localparam int mode_cross    = 5;

    // one stage entry with its fields packed from the most significant bit
    typedef struct packed {
        spu_pkg::unit_id_t  unit_id;
        spu_pkg::quad_t     rt_value;
        logic               wrt_en;
        spu_pkg::reg_addr_t rt_address;
        spu_pkg::unit_lat_t unit_lat;
    } entry_t;

    logic clock = 1'b0;
    logic reset;
    logic ep_issue_valid;
    logic op_issue_valid;
    fwd_pkg::stage_word_t ep_stage [fwd_pkg::num_stages];
    fwd_pkg::stage_word_t op_stage [fwd_pkg::num_stages];
    spu_pkg::reg_addr_t ra_address_ep, rb_address_ep, rc_address_ep;
    spu_pkg::reg_addr_t ra_address_op, rb_address_op;
    spu_pkg::quad_t ra_value_ep, rb_value_ep, rc_value_ep;
    spu_pkg::quad_t ra_value_op, rb_value_op;
    logic ep_operand_valid;
    logic op_operand_valid;
    spu_pkg::quad_t ra_value_fw_ep, rb_value_fw_ep, rc_value_fw_ep;
    spu_pkg::quad_t ra_value_fw_op, rb_value_fw_op;

    integer seed;
    string test_name;
    entry_t ep_entry [fwd_pkg::num_stages];
    entry_t op_entry [fwd_pkg::num_stages];
    spu_pkg::reg_addr_t ep_src [3];
    spu_pkg::reg_addr_t op_src [2];
    spu_pkg::quad_t ep_reg [3];
    spu_pkg::quad_t op_reg [2];
    logic [3*128-1:0] ep_exp_q [$];
    logic [2*128-1:0] op_exp_q [$];
    logic [3*128-1:0] ep_exp;
    logic [2*128-1:0] op_exp;
    logic ep_exp_set = 1'b0;
    logic op_exp_set = 1'b0;
    logic ep_issue_seen;
    logic op_issue_seen;

    forward_unit i_forward_unit (
        .clock            (clock),
        .reset            (reset),
        .ep_issue_valid   (ep_issue_valid),
        .ep_stage         (ep_stage),
        .ra_address_ep    (ra_address_ep),
        .rb_address_ep    (rb_address_ep),
        .rc_address_ep    (rc_address_ep),
        .ra_value_ep      (ra_value_ep),
        .rb_value_ep      (rb_value_ep),
        .rc_value_ep      (rc_value_ep),
        .op_issue_valid   (op_issue_valid),
        .op_stage         (op_stage),
        .ra_address_op    (ra_address_op),
        .rb_address_op    (rb_address_op),
        .ra_value_op      (ra_value_op),
        .rb_value_op      (rb_value_op),
        .ep_operand_valid (ep_operand_valid),
        .ra_value_fw_ep   (ra_value_fw_ep),
        .rb_value_fw_ep   (rb_value_fw_ep),
        .rc_value_fw_ep   (rc_value_fw_ep),
        .op_operand_valid (op_operand_valid),
        .ra_value_fw_op   (ra_value_fw_op),
        .rb_value_fw_op   (rb_value_fw_op)
    );

    always #(clock_period / 2) clock = ~clock;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic spu_pkg::quad_t rand_quad();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic entry_t make_ready(input entry_t e, input int idx);
        e.unit_id  = spu_pkg::unit_id_t'(1 + rand_below(7));
        e.wrt_en   = 1'b1;
        e.unit_lat = spu_pkg::unit_lat_t'(rand_below(idx + 1));
        return e;
    endfunction

    // a matching entry that must not forward for one of three reasons
    function automatic entry_t make_blocked(input entry_t e, input int idx);
        e = make_ready(e, idx);
        case (rand_below(3))
            0: e.unit_lat = spu_pkg::unit_lat_t'(idx + 1 + rand_below(15 - idx));
            1: e.wrt_en = 1'b0;
            default: e.unit_id = '0;
        endcase
        return e;
    endfunction

    function automatic entry_t draw_entry(input int mode, input int idx);
        entry_t e;
        e.unit_id    = spu_pkg::unit_id_t'(rand_below(8));
        e.rt_value   = rand_quad();
        e.wrt_en     = (rand_below(4) != 0);
        e.rt_address = spu_pkg::reg_addr_t'(rand_below(8));
        e.unit_lat   = spu_pkg::unit_lat_t'(rand_below(10));
        case (mode)
            mode_none: e.rt_address = spu_pkg::reg_addr_t'(8 + rand_below(8));
            mode_ready: e = make_ready(e, idx);
            mode_blocked: e = make_blocked(e, idx);
            mode_priority: begin
                e.rt_address = spu_pkg::reg_addr_t'(rand_below(2));
                if (rand_below(2) == 0) begin
                    e = make_ready(e, idx);
                end else begin
                    e = make_blocked(e, idx);
                end
            end
            default: begin
            end
        endcase
        return e;
    endfunction

    // the youngest ready entry with the right target wins and otherwise the register file
    function automatic spu_pkg::quad_t expected_operand(input logic odd,
            input spu_pkg::reg_addr_t src, input spu_pkg::quad_t reg_val);
        entry_t e;
        spu_pkg::quad_t result;
        logic found;
        result = reg_val;
        found = 1'b0;
        for (int s = 1; s <= fwd_pkg::num_stages; s++) begin
            e = odd ? op_entry[s-1] : ep_entry[s-1];
            if (!found && e.unit_id != 0 && e.wrt_en && e.unit_lat <= s
                    && e.rt_address == src) begin
                result = e.rt_value;
                found = 1'b1;
            end
        end
        return result;
    endfunction

    task automatic check_value(input string what, input logic [127:0] expected,
            input logic [127:0] actual);
        if (actual !== expected) begin
            $display("error test %s %s expected %h actual %h",
                     test_name, what, expected, actual);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic drive_inputs(input logic ep_go, input logic op_go);
        for (int i = 0; i < fwd_pkg::num_stages; i++) begin
            ep_stage[i] <= ep_entry[i];
            op_stage[i] <= op_entry[i];
        end
        ra_address_ep <= ep_src[0];
        rb_address_ep <= ep_src[1];
        rc_address_ep <= ep_src[2];
        ra_value_ep <= ep_reg[0];
        rb_value_ep <= ep_reg[1];
        rc_value_ep <= ep_reg[2];
        ra_address_op <= op_src[0];
        rb_address_op <= op_src[1];
        ra_value_op <= op_reg[0];
        rb_value_op <= op_reg[1];
        ep_issue_valid <= ep_go;
        op_issue_valid <= op_go;
    endtask

    task automatic run_test(input string name, input int mode, input int issue_pct);
        int ep_mode;
        int op_mode;
        int addr_range;
        logic ep_go;
        logic op_go;
        test_name = name;
        // in the cross test the odd pipe never targets an address below 8
        ep_mode = (mode == mode_cross) ? mode_random : mode;
        op_mode = (mode == mode_cross) ? mode_none : mode;
        addr_range = (mode == mode_priority) ? 2 : 8;
        repeat (test_cycles) begin
            @(posedge clock);
            for (int i = 0; i < fwd_pkg::num_stages; i++) begin
                ep_entry[i] = draw_entry(ep_mode, i + 1);
                op_entry[i] = draw_entry(op_mode, i + 1);
            end
            for (int k = 0; k < 3; k++) begin
                ep_src[k] = spu_pkg::reg_addr_t'(rand_below(addr_range));
                ep_reg[k] = rand_quad();
            end
            for (int k = 0; k < 2; k++) begin
                op_src[k] = spu_pkg::reg_addr_t'(rand_below(addr_range));
                op_reg[k] = rand_quad();
            end
            ep_go = (rand_below(100) < issue_pct);
            op_go = (rand_below(100) < issue_pct);
            if (ep_go) begin
                ep_exp_q.push_back({expected_operand(1'b0, ep_src[0], ep_reg[0]),
                                    expected_operand(1'b0, ep_src[1], ep_reg[1]),
                                    expected_operand(1'b0, ep_src[2], ep_reg[2])});
            end
            if (op_go) begin
                op_exp_q.push_back({expected_operand(1'b1, op_src[0], op_reg[0]),
                                    expected_operand(1'b1, op_src[1], op_reg[1])});
            end
            drive_inputs(ep_go, op_go);
        end
        @(posedge clock);
        drive_inputs(1'b0, 1'b0);
        @(posedge clock);
    endtask

    // operand valid should follow the issue sampled one edge earlier
    always @(posedge clock) begin
        ep_issue_seen <= reset ? 1'b0 : ep_issue_valid;
        op_issue_seen <= reset ? 1'b0 : op_issue_valid;
    end

    always @(negedge clock) begin
        check_value("ep operand valid", ep_issue_seen, ep_operand_valid);
        check_value("op operand valid", op_issue_seen, op_operand_valid);
        if (ep_operand_valid === 1'b1) begin
            ep_exp = ep_exp_q.pop_front();
            ep_exp_set = 1'b1;
        end
        if (op_operand_valid === 1'b1) begin
            op_exp = op_exp_q.pop_front();
            op_exp_set = 1'b1;
        end
        // between issues the operand register keeps the last issued values
        if (ep_exp_set) begin
            check_value("ra ep", ep_exp[383:256], ra_value_fw_ep);
            check_value("rb ep", ep_exp[255:128], rb_value_fw_ep);
            check_value("rc ep", ep_exp[127:0], rc_value_fw_ep);
        end
        if (op_exp_set) begin
            check_value("ra op", op_exp[255:128], ra_value_fw_op);
            check_value("rb op", op_exp[127:0], rb_value_fw_op);
        end
    end

    initial begin
        #(watchdog_cycles * clock_period);
        $display("the run timed out before all tests completed");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed = 32'h2935_da1b;
        test_name = "reset";
        reset = 1'b1;
        for (int i = 0; i < fwd_pkg::num_stages; i++) begin
            ep_entry[i] = '0;
            op_entry[i] = '0;
        end
        ep_src = '{default: '0};
        op_src = '{default: '0};
        ep_reg = '{default: '0};
        op_reg = '{default: '0};
        drive_inputs(1'b0, 1'b0);
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;

        run_test("valid_timing", mode_random, 60);
        run_test("no_match", mode_none, 90);
        run_test("forward_all", mode_ready, 90);
        run_test("blocked_entries", mode_blocked, 90);
        run_test("youngest_wins", mode_priority, 90);
        run_test("pipe_isolation", mode_cross, 90);

        if (ep_exp_q.size() != 0 || op_exp_q.size() != 0) begin
            $display("some issues never produced an operand valid");
            $display("Finished with errors");
            $fatal(1, "expected operands left over");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/spu_pkg.sv
rtl/fwd_pkg.sv
rtl/result_tap.sv
rtl/operand_select.sv
rtl/pipe_bypass.sv
rtl/forward_unit.sv
dv/forward_unit_chk.sv
dv/forward_unit_tb.sv

// ==== Bender.yml ====
package:
  name: forward_unit

sources:
  # packages first, then the bypass network bottom up
  - rtl/spu_pkg.sv
  - rtl/fwd_pkg.sv
  - rtl/result_tap.sv
  - rtl/operand_select.sv
  - rtl/pipe_bypass.sv
  - rtl/forward_unit.sv

  - target: test
    files:
      - dv/forward_unit_chk.sv
      - dv/forward_unit_tb.sv
